// ==== Makefile ====
# Verilator build and run of the integer issue slice

VERILATOR ?= verilator
TOP       ?= int_exec_tb
FILELIST  ?= int_exec_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= === PASS ===
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q -F -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/fu_alu.sv ====
`default_nettype none

module fu_alu
    import int_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // issued op from the reservation station
    input  logic      issue_valid,
    input  rob_id_t   iss_rob_id,
    input  phy_idx_t  iss_rd_phy,
    input  arch_idx_t iss_rd_arch,
    input  logic      iss_op1_sel,
    input  logic      iss_op2_sel,
    input  word_t     iss_imm,
    input  fu_op_t    iss_fu_op,
    input  word_t     iss_rs1_value,
    input  word_t     iss_rs2_value,

    // common data bus, registered
    output logic      cdb_valid,
    output rob_id_t   cdb_rob_id,
    output phy_idx_t  cdb_rd_phy,
    output arch_idx_t cdb_rd_arch,
    output word_t     cdb_value
);

    word_t              op1;
    word_t              op2;
    logic [SHAMT_W-1:0] shamt;
    word_t              result;

    ////////////////////////////////////////////////////////////
    // operands
    ////////////////////////////////////////////////////////////

    assign op1   = (iss_op1_sel == OP1_RS1) ? iss_rs1_value : '0;
    assign op2   = (iss_op2_sel == OP2_RS2) ? iss_rs2_value : iss_imm;
    assign shamt = op2[SHAMT_W-1:0];

    always_comb begin
        case (iss_fu_op)
            FU_ADD:  result = op1 + op2;
            FU_SUB:  result = op1 - op2;
            FU_AND:  result = op1 & op2;
            FU_OR:   result = op1 | op2;
            FU_XOR:  result = op1 ^ op2;
            FU_SLL:  result = op1 << shamt;
            FU_SRL:  result = op1 >> shamt;
            FU_SRA:  result = word_t'($signed(op1) >>> shamt);
            // compares give 0 or 1
            FU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            FU_SLTU: result = {{(XLEN-1){1'b0}}, op1 < op2};
            default: result = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // result register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= issue_valid;
        end
    end

    // tags and value only move when something issues
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            cdb_rob_id  <= iss_rob_id;
            cdb_rd_phy  <= iss_rd_phy;
            cdb_rd_arch <= iss_rd_arch;
            cdb_value   <= result;
        end
    end

endmodule

`default_nettype wire

// ==== hw/int_exec_top.sv ====
`default_nettype none

module int_exec_top
    import int_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // dispatch
    input  logic      [ID_WIDTH-1:0]  ds_valid,
    input  rob_id_t   [ID_WIDTH-1:0]  ds_rob_id,
    input  phy_idx_t  [ID_WIDTH-1:0]  ds_rs1_phy,
    input  logic      [ID_WIDTH-1:0]  ds_rs1_ready,
    input  phy_idx_t  [ID_WIDTH-1:0]  ds_rs2_phy,
    input  logic      [ID_WIDTH-1:0]  ds_rs2_ready,
    input  phy_idx_t  [ID_WIDTH-1:0]  ds_rd_phy,
    input  arch_idx_t [ID_WIDTH-1:0]  ds_rd_arch,
    input  logic      [ID_WIDTH-1:0]  ds_op1_sel,
    input  logic      [ID_WIDTH-1:0]  ds_op2_sel,
    input  word_t     [ID_WIDTH-1:0]  ds_imm,
    input  fu_op_t    [ID_WIDTH-1:0]  ds_fu_op,
    output logic                      ds_ready,

    // common data bus
    output logic                      cdb_valid,
    output rob_id_t                   cdb_rob_id,
    output phy_idx_t                  cdb_rd_phy,
    output arch_idx_t                 cdb_rd_arch,
    output word_t                     cdb_value
);

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    phy_idx_t  rs1_phy;
    phy_idx_t  rs2_phy;
    word_t     rs1_value;
    word_t     rs2_value;

    logic      issue_valid;
    rob_id_t   iss_rob_id;
    phy_idx_t  iss_rd_phy;
    arch_idx_t iss_rd_arch;
    logic      iss_op1_sel;
    logic      iss_op2_sel;
    word_t     iss_imm;
    fu_op_t    iss_fu_op;
    word_t     iss_rs1_value;
    word_t     iss_rs2_value;

    int_rs u_int_rs (
        .clk           (clk),
        .rst           (rst),
        .ds_valid      (ds_valid),
        .ds_rob_id     (ds_rob_id),
        .ds_rs1_phy    (ds_rs1_phy),
        .ds_rs1_ready  (ds_rs1_ready),
        .ds_rs2_phy    (ds_rs2_phy),
        .ds_rs2_ready  (ds_rs2_ready),
        .ds_rd_phy     (ds_rd_phy),
        .ds_rd_arch    (ds_rd_arch),
        .ds_op1_sel    (ds_op1_sel),
        .ds_op2_sel    (ds_op2_sel),
        .ds_imm        (ds_imm),
        .ds_fu_op      (ds_fu_op),
        .ds_ready      (ds_ready),
        .rs1_phy       (rs1_phy),
        .rs2_phy       (rs2_phy),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value),
        .cdb_valid     (cdb_valid),
        .cdb_rd_phy    (cdb_rd_phy),
        .cdb_value     (cdb_value),
        .issue_valid   (issue_valid),
        .iss_rob_id    (iss_rob_id),
        .iss_rd_phy    (iss_rd_phy),
        .iss_rd_arch   (iss_rd_arch),
        .iss_op1_sel   (iss_op1_sel),
        .iss_op2_sel   (iss_op2_sel),
        .iss_imm       (iss_imm),
        .iss_fu_op     (iss_fu_op),
        .iss_rs1_value (iss_rs1_value),
        .iss_rs2_value (iss_rs2_value)
    );

    int_prf u_int_prf (
        .clk        (clk),
        .rst        (rst),
        .rs1_phy    (rs1_phy),
        .rs2_phy    (rs2_phy),
        .rs1_value  (rs1_value),
        .rs2_value  (rs2_value),
        .cdb_valid  (cdb_valid),
        .cdb_rd_phy (cdb_rd_phy),
        .cdb_value  (cdb_value)
    );

    // sole bus source
    fu_alu u_fu_alu (
        .clk           (clk),
        .rst           (rst),
        .issue_valid   (issue_valid),
        .iss_rob_id    (iss_rob_id),
        .iss_rd_phy    (iss_rd_phy),
        .iss_rd_arch   (iss_rd_arch),
        .iss_op1_sel   (iss_op1_sel),
        .iss_op2_sel   (iss_op2_sel),
        .iss_imm       (iss_imm),
        .iss_fu_op     (iss_fu_op),
        .iss_rs1_value (iss_rs1_value),
        .iss_rs2_value (iss_rs2_value),
        .cdb_valid     (cdb_valid),
        .cdb_rob_id    (cdb_rob_id),
        .cdb_rd_phy    (cdb_rd_phy),
        .cdb_rd_arch   (cdb_rd_arch),
        .cdb_value     (cdb_value)
    );

endmodule

`default_nettype wire

// ==== hw/int_pkg.sv ====
`default_nettype none

package int_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN        = 32;
    localparam int SHAMT_W     = 5;

    // physical register file
    localparam int PRF_DEPTH   = 64;
    localparam int PRF_IDX     = 6;

    // architectural destination and reorder buffer tag
    localparam int ARF_IDX     = 5;
    localparam int ROB_IDX     = 5;

    // dispatch slots per cycle
    localparam int ID_WIDTH    = 2;

    // integer reservation station
    localparam int INTRS_DEPTH = 8;
    localparam int INTRS_IDX   = 3;

    typedef logic [XLEN-1:0]    word_t;
    typedef logic [PRF_IDX-1:0] phy_idx_t;
    typedef logic [ARF_IDX-1:0] arch_idx_t;
    typedef logic [ROB_IDX-1:0] rob_id_t;
    typedef logic [3:0]         fu_op_t;

    ////////////////////////////////////////////////////////////
    // alu opcodes
    ////////////////////////////////////////////////////////////

    localparam fu_op_t FU_ADD  = 4'd0;
    localparam fu_op_t FU_SUB  = 4'd1;
    localparam fu_op_t FU_AND  = 4'd2;
    localparam fu_op_t FU_OR   = 4'd3;
    localparam fu_op_t FU_XOR  = 4'd4;
    localparam fu_op_t FU_SLL  = 4'd5;
    localparam fu_op_t FU_SRL  = 4'd6;
    localparam fu_op_t FU_SRA  = 4'd7;
    localparam fu_op_t FU_SLT  = 4'd8;
    localparam fu_op_t FU_SLTU = 4'd9;

    ////////////////////////////////////////////////////////////
    // operand selects
    ////////////////////////////////////////////////////////////

    // first operand
    localparam logic OP1_ZERO = 1'b0;
    localparam logic OP1_RS1  = 1'b1;

    // second operand
    localparam logic OP2_IMM  = 1'b0;
    localparam logic OP2_RS2  = 1'b1;

endpackage

`default_nettype wire

// ==== hw/int_prf.sv ====
`default_nettype none

module int_prf
    import int_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // read ports from the reservation station
    input  phy_idx_t rs1_phy,
    input  phy_idx_t rs2_phy,
    output word_t    rs1_value,
    output word_t    rs2_value,

    // write port from the common data bus
    input  logic     cdb_valid,
    input  phy_idx_t cdb_rd_phy,
    input  word_t    cdb_value
);

    word_t regs [PRF_DEPTH];

    ////////////////////////////////////////////////////////////
    // write
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < PRF_DEPTH; i++) begin
                regs[i] <= '0;
            end
        end else if (cdb_valid) begin
            regs[cdb_rd_phy] <= cdb_value;
        end
    end

    ////////////////////////////////////////////////////////////
    // read
    ////////////////////////////////////////////////////////////

    // no write-through here, the station muxes in the bus value
    assign rs1_value = regs[rs1_phy];
    assign rs2_value = regs[rs2_phy];

endmodule

`default_nettype wire

// ==== hw/int_rs.sv ====
`default_nettype none

module int_rs
    import int_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,

    // dispatch, one lane per slot, slot 0 oldest
    input  logic      [ID_WIDTH-1:0]  ds_valid,
    input  rob_id_t   [ID_WIDTH-1:0]  ds_rob_id,
    input  phy_idx_t  [ID_WIDTH-1:0]  ds_rs1_phy,
    input  logic      [ID_WIDTH-1:0]  ds_rs1_ready,
    input  phy_idx_t  [ID_WIDTH-1:0]  ds_rs2_phy,
    input  logic      [ID_WIDTH-1:0]  ds_rs2_ready,
    input  phy_idx_t  [ID_WIDTH-1:0]  ds_rd_phy,
    input  arch_idx_t [ID_WIDTH-1:0]  ds_rd_arch,
    input  logic      [ID_WIDTH-1:0]  ds_op1_sel,
    input  logic      [ID_WIDTH-1:0]  ds_op2_sel,
    input  word_t     [ID_WIDTH-1:0]  ds_imm,
    input  fu_op_t    [ID_WIDTH-1:0]  ds_fu_op,
    output logic                      ds_ready,

    // register file read
    output phy_idx_t                  rs1_phy,
    output phy_idx_t                  rs2_phy,
    input  word_t                     rs1_value,
    input  word_t                     rs2_value,

    // common data bus snoop
    input  logic                      cdb_valid,
    input  phy_idx_t                  cdb_rd_phy,
    input  word_t                     cdb_value,

    // issue to the alu
    output logic                      issue_valid,
    output rob_id_t                   iss_rob_id,
    output phy_idx_t                  iss_rd_phy,
    output arch_idx_t                 iss_rd_arch,
    output logic                      iss_op1_sel,
    output logic                      iss_op2_sel,
    output word_t                     iss_imm,
    output fu_op_t                    iss_fu_op,
    output word_t                     iss_rs1_value,
    output word_t                     iss_rs2_value
);

    typedef enum logic [1:0] {
        UPD_SELF,
        UPD_NEXT,
        UPD_PUSH
    } upd_sel_t;

    // entry storage, index 0 is the oldest
    logic      free_q    [INTRS_DEPTH];
    rob_id_t   rob_id_q  [INTRS_DEPTH];
    phy_idx_t  rs1_phy_q [INTRS_DEPTH];
    logic      rs1_rdy_q [INTRS_DEPTH];
    phy_idx_t  rs2_phy_q [INTRS_DEPTH];
    logic      rs2_rdy_q [INTRS_DEPTH];
    phy_idx_t  rd_phy_q  [INTRS_DEPTH];
    arch_idx_t rd_arch_q [INTRS_DEPTH];
    logic      op1_sel_q [INTRS_DEPTH];
    logic      op2_sel_q [INTRS_DEPTH];
    word_t     imm_q     [INTRS_DEPTH];
    fu_op_t    fu_op_q   [INTRS_DEPTH];

    // occupied count, one bit wider than the index
    logic [INTRS_IDX:0]   top_q;
    logic [INTRS_IDX:0]   top_d;

    logic                 push_en   [ID_WIDTH];
    logic [INTRS_IDX-1:0] push_idx  [ID_WIDTH];
    logic                 push_wk1  [ID_WIDTH];
    logic                 push_wk2  [ID_WIDTH];
    upd_sel_t             upd_sel   [INTRS_DEPTH];
    logic                 wake1     [INTRS_DEPTH];
    logic                 wake2     [INTRS_DEPTH];
    logic [INTRS_IDX-1:0] issue_idx;

    // entry that shifts into slot i on a pop
    function automatic int up(input int i);
        return (i < INTRS_DEPTH - 1) ? i + 1 : i;
    endfunction

    // two free entries needed, whatever the slots carry
    assign ds_ready = (top_q <= (INTRS_IDX+1)'(INTRS_DEPTH - ID_WIDTH));

    ////////////////////////////////////////////////////////////
    // wakeup, select
    ////////////////////////////////////////////////////////////

    always_comb begin
        issue_valid = 1'b0;
        issue_idx   = '0;
        for (int i = 0; i < INTRS_DEPTH; i++) begin
            wake1[i] = cdb_valid && (rs1_phy_q[i] == cdb_rd_phy);
            wake2[i] = cdb_valid && (rs2_phy_q[i] == cdb_rd_phy);
            // lowest occupied entry with both sources satisfied
            if (!issue_valid && !free_q[i]
                && ((op1_sel_q[i] == OP1_ZERO) || rs1_rdy_q[i] || wake1[i])
                && ((op2_sel_q[i] == OP2_IMM) || rs2_rdy_q[i] || wake2[i])) begin
                issue_valid = 1'b1;
                issue_idx   = INTRS_IDX'(i);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // push placement and compression
    ////////////////////////////////////////////////////////////

    always_comb begin
        // pushes land on top of the post-pop queue
        top_d = top_q - (INTRS_IDX+1)'(issue_valid);
        for (int j = 0; j < ID_WIDTH; j++) begin
            push_en[j]  = ds_valid[j] && ds_ready;
            push_idx[j] = top_d[INTRS_IDX-1:0];
            push_wk1[j] = ds_rs1_ready[j] || (cdb_valid && (ds_rs1_phy[j] == cdb_rd_phy));
            push_wk2[j] = ds_rs2_ready[j] || (cdb_valid && (ds_rs2_phy[j] == cdb_rd_phy));
            if (push_en[j]) begin
                top_d = top_d + 1'b1;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < INTRS_DEPTH; i++) begin
            upd_sel[i] = UPD_SELF;
            if (issue_valid && (INTRS_IDX'(i) >= issue_idx)) begin
                upd_sel[i] = UPD_NEXT;
            end
            for (int j = 0; j < ID_WIDTH; j++) begin
                if (push_en[j] && (push_idx[j] == INTRS_IDX'(i))) begin
                    upd_sel[i] = UPD_PUSH;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            top_q <= '0;
            for (int i = 0; i < INTRS_DEPTH; i++) begin
                free_q[i] <= 1'b1;
            end
        end else begin
            top_q <= top_d;
            for (int i = 0; i < INTRS_DEPTH; i++) begin
                case (upd_sel[i])
                    UPD_NEXT: free_q[i] <= (i < INTRS_DEPTH - 1) ? free_q[up(i)] : 1'b1;
                    UPD_PUSH: free_q[i] <= 1'b0;
                    default:  free_q[i] <= free_q[i];
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < INTRS_DEPTH; i++) begin
            case (upd_sel[i])
                UPD_NEXT: begin
                    rob_id_q[i]  <= rob_id_q[up(i)];
                    rs1_phy_q[i] <= rs1_phy_q[up(i)];
                    rs1_rdy_q[i] <= rs1_rdy_q[up(i)] || wake1[up(i)];
                    rs2_phy_q[i] <= rs2_phy_q[up(i)];
                    rs2_rdy_q[i] <= rs2_rdy_q[up(i)] || wake2[up(i)];
                    rd_phy_q[i]  <= rd_phy_q[up(i)];
                    rd_arch_q[i] <= rd_arch_q[up(i)];
                    op1_sel_q[i] <= op1_sel_q[up(i)];
                    op2_sel_q[i] <= op2_sel_q[up(i)];
                    imm_q[i]     <= imm_q[up(i)];
                    fu_op_q[i]   <= fu_op_q[up(i)];
                end
                UPD_PUSH: begin
                    for (int j = 0; j < ID_WIDTH; j++) begin
                        if (push_en[j] && (push_idx[j] == INTRS_IDX'(i))) begin
                            rob_id_q[i]  <= ds_rob_id[j];
                            rs1_phy_q[i] <= ds_rs1_phy[j];
                            rs1_rdy_q[i] <= push_wk1[j];
                            rs2_phy_q[i] <= ds_rs2_phy[j];
                            rs2_rdy_q[i] <= push_wk2[j];
                            rd_phy_q[i]  <= ds_rd_phy[j];
                            rd_arch_q[i] <= ds_rd_arch[j];
                            op1_sel_q[i] <= ds_op1_sel[j];
                            op2_sel_q[i] <= ds_op2_sel[j];
                            imm_q[i]     <= ds_imm[j];
                            fu_op_q[i]   <= ds_fu_op[j];
                        end
                    end
                end
                default: begin
                    // entry stays, only ready bits can rise
                    rs1_rdy_q[i] <= rs1_rdy_q[i] || wake1[i];
                    rs2_rdy_q[i] <= rs2_rdy_q[i] || wake2[i];
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // issue and operand bypass
    ////////////////////////////////////////////////////////////

    assign rs1_phy = rs1_phy_q[issue_idx];
    assign rs2_phy = rs2_phy_q[issue_idx];

    assign iss_rob_id  = rob_id_q[issue_idx];
    assign iss_rd_phy  = rd_phy_q[issue_idx];
    assign iss_rd_arch = rd_arch_q[issue_idx];
    assign iss_op1_sel = op1_sel_q[issue_idx];
    assign iss_op2_sel = op2_sel_q[issue_idx];
    assign iss_imm     = imm_q[issue_idx];
    assign iss_fu_op   = fu_op_q[issue_idx];

    // register file is written only at the end of the broadcast cycle
    assign iss_rs1_value = (cdb_valid && (cdb_rd_phy == rs1_phy)) ? cdb_value : rs1_value;
    assign iss_rs2_value = (cdb_valid && (cdb_rd_phy == rs2_phy)) ? cdb_value : rs2_value;

endmodule

`default_nettype wire

// ==== int_exec_top.f ====
+incdir+verification
hw/int_pkg.sv
hw/int_prf.sv
hw/fu_alu.sv
hw/int_rs.sv
hw/int_exec_top.sv
verification/int_exec_tb.sv

// ==== verification/int_exec_model.svh ====
`ifndef INT_EXEC_MODEL_SVH
`define INT_EXEC_MODEL_SVH

////////////////////////////////////////////////////////////
// random numbers
////////////////////////////////////////////////////////////

logic [31:0] rng_state = 32'd53734;

function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

// alu rule on the already selected operands
function automatic word_t alu_ref(input fu_op_t op, input word_t a, input word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
        FU_ADD:  return a + b;
        FU_SUB:  return a - b;
        FU_AND:  return a & b;
        FU_OR:   return a | b;
        FU_XOR:  return a ^ b;
        FU_SLL:  return a << sh;
        FU_SRL:  return a >> sh;
        FU_SRA:  return $unsigned($signed(a) >>> sh);
        FU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        FU_SLTU: return (a < b) ? 32'd1 : 32'd0;
        default: return '0;
    endcase
endfunction

////////////////////////////////////////////////////////////
// rename state, busy table, scoreboard
////////////////////////////////////////////////////////////

word_t     phy_val     [PRF_DEPTH];
logic      produced    [PRF_DEPTH];
logic      pending     [1 << ROB_IDX];
word_t     exp_value   [1 << ROB_IDX];
phy_idx_t  exp_rd_phy  [1 << ROB_IDX];
arch_idx_t exp_rd_arch [1 << ROB_IDX];
phy_idx_t  next_phy;
rob_id_t   next_rob;
phy_idx_t  recent [$];

function automatic void model_reset();
    for (int i = 0; i < PRF_DEPTH; i++) begin
        phy_val[i]  = '0;
        produced[i] = 1'b1;
    end
    for (int i = 0; i < (1 << ROB_IDX); i++) begin
        pending[i] = 1'b0;
    end
    next_phy = phy_idx_t'(1);
    next_rob = '0;
endfunction

// round robin over 1..63, phy 0 stays zero
function automatic phy_idx_t alloc_phy();
    phy_idx_t p;
    p = next_phy;
    next_phy = (next_phy == phy_idx_t'(PRF_DEPTH - 1)) ? phy_idx_t'(1) : next_phy + 1'b1;
    produced[p] = 1'b0;
    recent.push_back(p);
    if (recent.size() > 16) begin
        void'(recent.pop_front());
    end
    return p;
endfunction

// source from the recent window, zero reg when a produced one is needed
function automatic phy_idx_t pick_src(input logic need_produced);
    phy_idx_t    p;
    logic [31:0] r;
    if (recent.size() == 0) return '0;
    r = next_rand();
    p = recent[r[7:0] % recent.size()];
    if (need_produced && !produced[p]) return '0;
    return p;
endfunction

`endif

// ==== verification/int_exec_tb.sv ====
`default_nettype none

module int_exec_tb
    import int_pkg::*;
();

    logic                      clk = 1'b0;
    logic                      rst;
    logic      [ID_WIDTH-1:0]  ds_valid;
    rob_id_t   [ID_WIDTH-1:0]  ds_rob_id;
    phy_idx_t  [ID_WIDTH-1:0]  ds_rs1_phy;
    logic      [ID_WIDTH-1:0]  ds_rs1_ready;
    phy_idx_t  [ID_WIDTH-1:0]  ds_rs2_phy;
    logic      [ID_WIDTH-1:0]  ds_rs2_ready;
    phy_idx_t  [ID_WIDTH-1:0]  ds_rd_phy;
    arch_idx_t [ID_WIDTH-1:0]  ds_rd_arch;
    logic      [ID_WIDTH-1:0]  ds_op1_sel;
    logic      [ID_WIDTH-1:0]  ds_op2_sel;
    word_t     [ID_WIDTH-1:0]  ds_imm;
    fu_op_t    [ID_WIDTH-1:0]  ds_fu_op;
    logic                      ds_ready;
    logic                      cdb_valid;
    rob_id_t                   cdb_rob_id;
    phy_idx_t                  cdb_rd_phy;
    arch_idx_t                 cdb_rd_arch;
    word_t                     cdb_value;

    int        errors = 0;
    int        timeouts = 0;
    int        in_flight = 0;
    int        accepted = 0;
    int        broadcasts = 0;
    int        full_cycles = 0;
    int        rst_cycles = 0;
    logic      order_mode = 1'b0;
    rob_id_t   order_q [$];
    phy_idx_t  last_rd = '0;
    phy_idx_t  hold_phy = '0;
    word_t     rel_imm;

    `include "int_exec_model.svh"

    int_exec_top DUT (.*);

    always #4 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // dispatch side
    ////////////////////////////////////////////////////////////

    // one renamed op into slot j with its expected result
    function automatic void put_op(input int j, input fu_op_t op, input logic s1,
                                   input logic s2, input phy_idx_t r1, input phy_idx_t r2,
                                   input word_t imm, input phy_idx_t rd);
        word_t   a;
        word_t   b;
        rob_id_t rob;
        rob = next_rob;
        next_rob = next_rob + 1'b1;
        a = (s1 == OP1_RS1) ? phy_val[r1] : '0;
        b = (s2 == OP2_RS2) ? phy_val[r2] : imm;
        ds_rob_id[j]    = rob;
        ds_rs1_phy[j]   = r1;
        ds_rs1_ready[j] = produced[r1];
        ds_rs2_phy[j]   = r2;
        ds_rs2_ready[j] = produced[r2];
        ds_rd_phy[j]    = rd;
        ds_rd_arch[j]   = arch_idx_t'(next_rand());
        ds_op1_sel[j]   = s1;
        ds_op2_sel[j]   = s2;
        ds_imm[j]       = imm;
        ds_fu_op[j]     = op;
        exp_value[rob]   = alu_ref(op, a, b);
        exp_rd_phy[rob]  = rd;
        exp_rd_arch[rob] = ds_rd_arch[j];
        pending[rob]     = 1'b1;
        phy_val[rd]      = exp_value[rob];
        last_rd          = rd;
        if (order_mode) begin
            order_q.push_back(rob);
        end
    endfunction

    // mode 0 imm load, 1 random, 2 ready sources, 3 chain, 4 reads the held reg
    function automatic void make_op(input int j, input int mode);
        logic [31:0] r;
        fu_op_t      op;
        logic        s1;
        logic        s2;
        phy_idx_t    r1;
        phy_idx_t    r2;
        word_t       imm;
        r   = next_rand();
        op  = fu_op_t'(r % 32'd10);
        s1  = r[8];
        s2  = r[9];
        imm = next_rand();
        r1  = pick_src(mode == 2);
        r2  = pick_src(mode == 2);
        case (mode)
            0: begin
                op = FU_ADD;
                s1 = OP1_ZERO;
                s2 = OP2_IMM;
            end
            3: begin
                r1 = last_rd;
                s1 = OP1_RS1;
            end
            4: begin
                r1 = hold_phy;
                s1 = OP1_RS1;
            end
            default: ;
        endcase
        put_op(j, op, s1, s2, r1, r2, imm, alloc_phy());
    endfunction

    // rob ids dispatched and never seen on the bus
    function automatic int count_pending();
        int n;
        n = 0;
        for (int i = 0; i < (1 << ROB_IDX); i++) begin
            if (pending[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ds_ready && n < 100) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!ds_ready) begin
            timeouts++;
            $display("timeout: ds_ready stayed low for %0d cycles", n);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (in_flight != 0 && n < 200) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (in_flight != 0) begin
            timeouts++;
            $display("timeout: %0d ops never came back on the bus", in_flight);
        end
    endtask

    task automatic push_pair();
        ds_valid = 2'b11;
        @(posedge clk);
        #1;
        ds_valid = '0;
    endtask

    task automatic send_ops(input int pairs, input int mode);
        for (int p = 0; p < pairs; p++) begin
            wait_ready();
            make_op(0, mode);
            make_op(1, mode);
            push_pair();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // bus monitor
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        int in_rs;
        if (rst) begin
            // first edge still sees unreset state
            if (rst_cycles > 0) begin
                assert (!cdb_valid && ds_ready) else begin
                    errors++;
                    $display("Fail %0t: in reset cdb_valid=%0b ds_ready=%0b",
                             $time, cdb_valid, ds_ready);
                end
            end
            rst_cycles++;
        end else begin
            // the op on the bus has already left the station
            in_rs = in_flight - int'(cdb_valid);
            assert (ds_ready == (in_rs <= INTRS_DEPTH - ID_WIDTH)) else begin
                errors++;
                $display("Fail %0t: ds_ready=%0b with %0d entries held", $time, ds_ready, in_rs);
            end
            if (!ds_ready) begin
                full_cycles++;
            end
            if (cdb_valid) begin
                assert (pending[cdb_rob_id]) else begin
                    errors++;
                    $display("Fail %0t: rob_id %0d not outstanding", $time, cdb_rob_id);
                end
                assert (cdb_value == exp_value[cdb_rob_id]) else begin
                    errors++;
                    $display("Fail %0t: rob_id %0d value %h, expected %h", $time,
                             cdb_rob_id, cdb_value, exp_value[cdb_rob_id]);
                end
                assert (cdb_rd_phy == exp_rd_phy[cdb_rob_id]
                        && cdb_rd_arch == exp_rd_arch[cdb_rob_id]) else begin
                    errors++;
                    $display("Fail %0t: rob_id %0d wrong destination %0d/%0d", $time,
                             cdb_rob_id, cdb_rd_phy, cdb_rd_arch);
                end
                if (order_q.size() > 0) begin
                    assert (cdb_rob_id == order_q[0]) else begin
                        errors++;
                        $display("Fail %0t: rob_id %0d out of order, expected %0d", $time,
                                 cdb_rob_id, order_q[0]);
                    end
                    void'(order_q.pop_front());
                end
                pending[cdb_rob_id]  = 1'b0;
                produced[cdb_rd_phy] = 1'b1;
                in_flight--;
                broadcasts++;
            end
            for (int j = 0; j < ID_WIDTH; j++) begin
                if (ds_valid[j] && ds_ready) begin
                    in_flight++;
                    accepted++;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        rst          = 1'b1;
        ds_valid     = '0;
        ds_rob_id    = '0;
        ds_rs1_phy   = '0;
        ds_rs1_ready = '0;
        ds_rs2_phy   = '0;
        ds_rs2_ready = '0;
        ds_rd_phy    = '0;
        ds_rd_arch   = '0;
        ds_op1_sel   = '0;
        ds_op2_sel   = '0;
        ds_imm       = '0;
        ds_fu_op     = '0;
        model_reset();
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!cdb_valid && ds_ready) else begin
            errors++;
            $display("Fail %0t: state after reset cdb_valid=%0b ds_ready=%0b",
                     $time, cdb_valid, ds_ready);
        end

        // immediate loads seed the registers
        send_ops(4, 0);
        wait_drain();
        send_ops(12, 1);
        wait_drain();
        send_ops(6, 3);
        wait_drain();

        // all sources ready so results come in dispatch order
        order_mode = 1'b1;
        send_ops(4, 2);
        wait_drain();
        order_mode = 1'b0;
        assert (order_q.size() == 0) else begin
            errors++;
            $display("Fail %0t: %0d ordered ops never seen", $time, order_q.size());
        end

        // back-pressure behind a held register
        hold_phy = alloc_phy();
        rel_imm  = next_rand();
        phy_val[hold_phy] = rel_imm;
        send_ops(3, 4);
        wait_ready();
        put_op(0, FU_ADD, OP1_ZERO, OP2_IMM, '0, '0, rel_imm, hold_phy);
        make_op(1, 4);
        push_pair();
        send_ops(3, 4);
        wait_drain();
        assert (full_cycles > 0 && count_pending() == 0) else begin
            errors++;
            $display("Fail %0t: full cycles %0d, %0d rob ids never broadcast",
                     $time, full_cycles, count_pending());
        end

        $display("errors: %0d  timeouts: %0d  accepted: %0d  broadcasts: %0d",
                 errors, timeouts, accepted, broadcasts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
